//--- source/trace_macros.svh
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Datapath widths
`define TRACE_WORD_W 32
`define TRACE_CHAR_W 8

// Nine status fields, index 9 is the CR/LF pseudo-label
`define TRACE_FIELDS 9
`define TRACE_LABEL_MAX 4
`define TRACE_IDX_W ($clog2(`TRACE_FIELDS + 1))
`define TRACE_POS_W ($clog2(`TRACE_LABEL_MAX))

// Mode code that selects tracing ("T")
`define TRACE_CMD 8'h54

`define ASCII_EQ 8'h3D
`define ASCII_CR 8'h0D
`define ASCII_LF 8'h0A

`endif

//--- source/trace_pkg.sv
`default_nettype none

`include "trace_macros.svh"

package trace_pkg;

    // One transmit word, read as a full value or as a padded character
    typedef union packed {
        logic [`TRACE_WORD_W-1:0] data;
        struct packed {
            logic [`TRACE_WORD_W-`TRACE_CHAR_W-1:0] pad;  // Zero for characters
            logic [`TRACE_CHAR_W-1:0]               chr;
        } ch;
    } tx_word_t;

endpackage

`default_nettype wire

//--- source/trace_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

interface tx_if;
    logic                        send;       // One-cycle transfer request
    logic                        abort;      // Mode left, drop pending request
    logic                        is_value;
    logic [`TRACE_IDX_W-1:0]     field_idx;
    logic [`TRACE_POS_W-1:0]     char_idx;
    logic [`TRACE_CHAR_W-1:0]    label_char;
    logic                        label_last;
    logic [`TRACE_WORD_W-1:0]    value;
    logic                        sent;       // Transfer acknowledged

    modport ctrl    (output send, abort, is_value, field_idx, char_idx,
                     input label_last, sent);
    modport rom     (input field_idx, char_idx, output label_char, label_last);
    modport capture (input field_idx, output value);
    modport port    (input send, abort, is_value, label_char, value, output sent);
endinterface

interface status_if;
    logic [`TRACE_WORD_W-1:0] npc;
    logic [`TRACE_WORD_W-1:0] pc;
    logic [`TRACE_WORD_W-1:0] ir;
    logic [`TRACE_WORD_W-1:0] ctl;
    logic [`TRACE_WORD_W-1:0] a;
    logic [`TRACE_WORD_W-1:0] b;
    logic [`TRACE_WORD_W-1:0] imm;
    logic [`TRACE_WORD_W-1:0] y;
    logic [`TRACE_WORD_W-1:0] mdr;

    modport src (output npc, pc, ir, ctl, a, b, imm, y, mdr);
    modport dst (input npc, pc, ir, ctl, a, b, imm, y, mdr);
endinterface

`default_nettype wire

//--- source/trace_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module trace_ctrl (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] mode,
    output logic       clk_cpu,
    output logic       capture,
    output logic       done,
    tx_if.ctrl         tx
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_STEP    = 3'd1;
    localparam logic [2:0] S_CAPTURE = 3'd2;
    localparam logic [2:0] S_LABEL   = 3'd3;
    localparam logic [2:0] S_VALUE   = 3'd4;
    localparam logic [2:0] S_EOL     = 3'd5;
    localparam logic [2:0] S_FINISH  = 3'd6;

    logic [2:0] state;
    logic       wait_sent;  // A transfer is owned by tx_port
    logic       mode_hit;

    assign mode_hit = (mode == `TRACE_CMD);
    assign tx.abort = ~mode_hit;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= S_IDLE;
            wait_sent    <= 1'b0;
            clk_cpu      <= 1'b0;
            capture      <= 1'b0;
            done         <= 1'b0;
            tx.send      <= 1'b0;
            tx.is_value  <= 1'b0;
            tx.field_idx <= '0;
            tx.char_idx  <= '0;
        end else begin
            tx.send <= 1'b0;
            clk_cpu <= 1'b0;
            capture <= 1'b0;
            done    <= 1'b0;
            if (!mode_hit) begin
                state     <= S_IDLE;  // Abort, dump in progress is lost
                wait_sent <= 1'b0;
            end else begin
                case (state)
                    S_IDLE: begin
                        clk_cpu      <= 1'b1;  // Single step pulse
                        wait_sent    <= 1'b0;
                        tx.field_idx <= '0;
                        tx.char_idx  <= '0;
                        state        <= S_STEP;
                    end
                    S_STEP: begin
                        capture <= 1'b1;
                        state   <= S_CAPTURE;
                    end
                    S_CAPTURE: state <= S_LABEL;
                    S_LABEL, S_EOL: begin
                        if (!wait_sent) begin
                            tx.send     <= 1'b1;
                            tx.is_value <= 1'b0;
                            wait_sent   <= 1'b1;
                        end else if (tx.sent) begin
                            wait_sent <= 1'b0;
                            if (!tx.label_last) begin
                                tx.char_idx <= tx.char_idx + 1'b1;
                            end else if (state == S_EOL) begin
                                done  <= 1'b1;
                                state <= S_FINISH;
                            end else begin
                                tx.char_idx <= '0;
                                state       <= S_VALUE;
                            end
                        end
                    end
                    S_VALUE: begin
                        if (!wait_sent) begin
                            tx.send     <= 1'b1;
                            tx.is_value <= 1'b1;
                            wait_sent   <= 1'b1;
                        end else if (tx.sent) begin
                            wait_sent    <= 1'b0;
                            tx.field_idx <= tx.field_idx + 1'b1;
                            // After MDR comes the CR/LF line end
                            if (tx.field_idx == `TRACE_FIELDS - 1) begin
                                state <= S_EOL;
                            end else begin
                                state <= S_LABEL;
                            end
                        end
                    end
                    S_FINISH: state <= S_IDLE;  // Repeats while mode stays
                    default:  state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/label_rom.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module label_rom (
    tx_if.rom tx
);

    logic [`TRACE_LABEL_MAX*`TRACE_CHAR_W-1:0] label_text;  // Left aligned
    logic [`TRACE_POS_W-1:0]                   last_pos;

    always_comb begin
        case (tx.field_idx)
            4'd0:    label_text = {"NPC", `ASCII_EQ};
            4'd1:    label_text = {"PC", `ASCII_EQ, 8'h00};
            4'd2:    label_text = {"IR", `ASCII_EQ, 8'h00};
            4'd3:    label_text = {"CTL", `ASCII_EQ};
            4'd4:    label_text = {"A", `ASCII_EQ, 16'h0000};
            4'd5:    label_text = {"B", `ASCII_EQ, 16'h0000};
            4'd6:    label_text = {"IMM", `ASCII_EQ};
            4'd7:    label_text = {"Y", `ASCII_EQ, 16'h0000};
            4'd8:    label_text = {"MDR", `ASCII_EQ};
            4'd9:    label_text = {`ASCII_CR, `ASCII_LF, 16'h0000};
            default: label_text = '0;
        endcase
    end

    always_comb begin
        case (tx.field_idx)
            4'd0, 4'd3, 4'd6, 4'd8: last_pos = 2'd3;
            4'd1, 4'd2:             last_pos = 2'd2;
            4'd4, 4'd5, 4'd7, 4'd9: last_pos = 2'd1;
            default:                last_pos = 2'd0;
        endcase
    end

    assign tx.label_char = label_text[(`TRACE_LABEL_MAX - 1 - 32'(tx.char_idx)) * `TRACE_CHAR_W
                                      +: `TRACE_CHAR_W];
    assign tx.label_last = (tx.char_idx == last_pos);

endmodule

`default_nettype wire

//--- source/status_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module status_capture (
    input  logic  clk,
    input  logic  rstn,
    input  logic  capture,
    status_if.dst status,
    tx_if.capture tx
);

    logic [`TRACE_WORD_W-1:0] npc_q;
    logic [`TRACE_WORD_W-1:0] pc_q;
    logic [`TRACE_WORD_W-1:0] ir_q;
    logic [`TRACE_WORD_W-1:0] ctl_q;
    logic [`TRACE_WORD_W-1:0] a_q;
    logic [`TRACE_WORD_W-1:0] b_q;
    logic [`TRACE_WORD_W-1:0] imm_q;
    logic [`TRACE_WORD_W-1:0] y_q;
    logic [`TRACE_WORD_W-1:0] mdr_q;

    // One snapshot per trace so the dump shows a single CPU state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            npc_q <= '0;
            pc_q  <= '0;
            ir_q  <= '0;
            ctl_q <= '0;
            a_q   <= '0;
            b_q   <= '0;
            imm_q <= '0;
            y_q   <= '0;
            mdr_q <= '0;
        end else if (capture) begin
            npc_q <= status.npc;
            pc_q  <= status.pc;
            ir_q  <= status.ir;
            ctl_q <= status.ctl;
            a_q   <= status.a;
            b_q   <= status.b;
            imm_q <= status.imm;
            y_q   <= status.y;
            mdr_q <= status.mdr;
        end
    end

    always_comb begin
        case (tx.field_idx)
            4'd0:    tx.value = npc_q;
            4'd1:    tx.value = pc_q;
            4'd2:    tx.value = ir_q;
            4'd3:    tx.value = ctl_q;
            4'd4:    tx.value = a_q;
            4'd5:    tx.value = b_q;
            4'd6:    tx.value = imm_q;
            4'd7:    tx.value = y_q;
            4'd8:    tx.value = mdr_q;
            default: tx.value = '0;  // Line end carries no value
        endcase
    end

endmodule

`default_nettype wire

//--- source/tx_port.sv
`timescale 1ns/100ps
`default_nettype none

module tx_port (
    input  logic               clk,
    input  logic               rstn,
    tx_if.port                 tx,
    input  logic               tx_ack,
    output logic               tx_req,
    output logic               tx_type,
    output trace_pkg::tx_word_t tx_data
);

    // Request handshake, held until the acknowledge is sampled
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_req  <= 1'b0;
            tx.sent <= 1'b0;
        end else begin
            tx.sent <= 1'b0;
            if (tx.abort) begin
                tx_req <= 1'b0;  // Mode deselected mid transfer
            end else if (tx.send) begin
                tx_req <= 1'b1;
            end else if (tx_req && tx_ack) begin
                tx_req  <= 1'b0;
                tx.sent <= 1'b1;
            end
        end
    end

    // Outgoing word, stable for the whole request
    always_ff @(posedge clk) begin
        if (tx.send) begin
            tx_type <= tx.is_value;
            if (tx.is_value) begin
                tx_data.data <= tx.value;
            end else begin
                tx_data.ch.pad <= '0;
                tx_data.ch.chr <= tx.label_char;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/trace_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module trace_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [7:0]               mode,
    input  logic [`TRACE_WORD_W-1:0] npc,
    input  logic [`TRACE_WORD_W-1:0] pc,
    input  logic [`TRACE_WORD_W-1:0] ir,
    input  logic [`TRACE_WORD_W-1:0] ctl,
    input  logic [`TRACE_WORD_W-1:0] a,
    input  logic [`TRACE_WORD_W-1:0] b,
    input  logic [`TRACE_WORD_W-1:0] imm,
    input  logic [`TRACE_WORD_W-1:0] y,
    input  logic [`TRACE_WORD_W-1:0] mdr,
    input  logic                     tx_ack,
    output logic                     tx_req,
    output logic                     tx_type,
    output trace_pkg::tx_word_t      tx_data,
    output logic                     clk_cpu,
    output logic                     done
);

    logic capture;

    tx_if     tx_bus ();
    status_if status_bus ();

    // CPU status words onto the internal bus
    assign status_bus.npc = npc;
    assign status_bus.pc  = pc;
    assign status_bus.ir  = ir;
    assign status_bus.ctl = ctl;
    assign status_bus.a   = a;
    assign status_bus.b   = b;
    assign status_bus.imm = imm;
    assign status_bus.y   = y;
    assign status_bus.mdr = mdr;

    trace_ctrl ctrl_i (
        .clk     (clk),
        .rstn    (rstn),
        .mode    (mode),
        .clk_cpu (clk_cpu),
        .capture (capture),
        .done    (done),
        .tx      (tx_bus.ctrl)
    );

    label_rom rom_i (
        .tx (tx_bus.rom)
    );

    status_capture capture_i (
        .clk     (clk),
        .rstn    (rstn),
        .capture (capture),
        .status  (status_bus.dst),
        .tx      (tx_bus.capture)
    );

    tx_port port_i (
        .clk     (clk),
        .rstn    (rstn),
        .tx      (tx_bus.port),
        .tx_ack  (tx_ack),
        .tx_req  (tx_req),
        .tx_type (tx_type),
        .tx_data (tx_data)
    );

endmodule

`default_nettype wire

//--- verification/trace_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module trace_assert (
    input logic                clk,
    input logic                rstn,
    input logic [7:0]          mode,
    input logic                tx_req,
    input logic                tx_ack,
    input logic                tx_type,
    input trace_pkg::tx_word_t tx_data,
    input logic                clk_cpu,
    input logic                done
);

    int   fail_count = 0;
    logic holding;

    // Request pending, no ack yet and no abort
    assign holding = tx_req && !tx_ack && (mode == `TRACE_CMD);

    req_held: assert property (@(posedge clk) disable iff (!rstn) holding |=> tx_req)
        else begin
            fail_count++;
            $error("tx_req dropped before tx_ack");
        end

    data_stable: assert property (@(posedge clk) disable iff (!rstn)
                                  holding |=> $stable(tx_data) && $stable(tx_type))
        else begin
            fail_count++;
            $error("tx_data or tx_type changed during a request");
        end

    step_apart: assert property (@(posedge clk) disable iff (!rstn) !(clk_cpu && tx_req))
        else begin
            fail_count++;
            $error("clk_cpu high during a request");
        end

    done_apart: assert property (@(posedge clk) disable iff (!rstn) !(done && tx_req))
        else begin
            fail_count++;
            $error("done high during a request");
        end

endmodule

bind trace_top trace_assert assert_i (
    .clk     (clk),
    .rstn    (rstn),
    .mode    (mode),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack),
    .tx_type (tx_type),
    .tx_data (tx_data),
    .clk_cpu (clk_cpu),
    .done    (done)
);

`default_nettype wire

//--- verification/trace_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "trace_macros.svh"

module trace_tb;
    import trace_pkg::*;

    localparam int TIMEOUT  = 200;
    localparam int PATTERNS = 4;
    localparam int XFERS    = 39;  // 28 label chars, 9 values, CR, LF

    logic                     clk;
    logic                     rstn;
    logic [7:0]               mode;
    logic [`TRACE_WORD_W-1:0] npc;
    logic [`TRACE_WORD_W-1:0] pc;
    logic [`TRACE_WORD_W-1:0] ir;
    logic [`TRACE_WORD_W-1:0] ctl;
    logic [`TRACE_WORD_W-1:0] a;
    logic [`TRACE_WORD_W-1:0] b;
    logic [`TRACE_WORD_W-1:0] imm;
    logic [`TRACE_WORD_W-1:0] y;
    logic [`TRACE_WORD_W-1:0] mdr;
    logic                     tx_ack;
    logic                     tx_req;
    logic                     tx_type;
    tx_word_t                 tx_data;
    logic                     clk_cpu;
    logic                     done;

    logic [`TRACE_WORD_W-1:0] pat_mem [0:PATTERNS*`TRACE_FIELDS*2-1];  // Label, value pairs
    integer                   seed;
    int                       cpu_pulses;
    int                       transfers;
    logic                     req_seen;

    trace_top dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .mode    (mode),
        .npc     (npc),
        .pc      (pc),
        .ir      (ir),
        .ctl     (ctl),
        .a       (a),
        .b       (b),
        .imm     (imm),
        .y       (y),
        .mdr     (mdr),
        .tx_ack  (tx_ack),
        .tx_req  (tx_req),
        .tx_type (tx_type),
        .tx_data (tx_data),
        .clk_cpu (clk_cpu),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Step pulses and new requests as seen on the DUT outputs
    always @(negedge clk) begin
        if (clk_cpu === 1'b1) cpu_pulses++;
        if (tx_req === 1'b1 && req_seen !== 1'b1) transfers++;
        req_seen <= tx_req;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_char(input string name, input tx_word_t got, input tx_word_t exp);
        if (got.ch !== exp.ch) begin
            stop_with_error($sformatf("Fail at %0t: %s expected %h got %h",
                                      $time, name, exp.ch, got.ch));
        end
    endtask

    task automatic check_value(input string name, input tx_word_t got, input tx_word_t exp);
        if (got.data !== exp.data) begin
            stop_with_error($sformatf("Fail at %0t: %s expected %h got %h",
                                      $time, name, exp.data, got.data));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail at %0t: %s expected %b got %b",
                                      $time, name, exp, got));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_error($sformatf("Fail at %0t: %s expected %0d got %0d",
                                      $time, name, exp, got));
        end
    endtask

    // Status ports from one pattern XORed with the mask
    task automatic apply_status(input int pat, input logic [`TRACE_WORD_W-1:0] mask);
        int base;
        base = pat * `TRACE_FIELDS * 2;
        @(posedge clk);
        npc <= pat_mem[base + 1] ^ mask;
        pc  <= pat_mem[base + 3] ^ mask;
        ir  <= pat_mem[base + 5] ^ mask;
        ctl <= pat_mem[base + 7] ^ mask;
        a   <= pat_mem[base + 9] ^ mask;
        b   <= pat_mem[base + 11] ^ mask;
        imm <= pat_mem[base + 13] ^ mask;
        y   <= pat_mem[base + 15] ^ mask;
        mdr <= pat_mem[base + 17] ^ mask;
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("tx_req", tx_req, 1'b0);
            check_bit("clk_cpu", clk_cpu, 1'b0);
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic wait_request();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
            cycles++;
            if (cycles > TIMEOUT) stop_with_error("Timeout while waiting for a transmit request");
        end while (tx_req !== 1'b1);
    endtask

    // One acknowledge pulse after 0 to 3 cycles
    task automatic ack_request();
        int delay;
        int cycles;
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        tx_ack <= 1'b1;
        @(posedge clk);
        tx_ack <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) stop_with_error("Timeout: tx_req stayed high after tx_ack");
        end while (tx_req !== 1'b0);
    endtask

    task automatic get_transfer(output tx_word_t word, output logic typ);
        wait_request();
        word = tx_data;
        typ  = tx_type;
        ack_request();
    endtask

    task automatic expect_char(input logic [`TRACE_CHAR_W-1:0] c);
        tx_word_t word;
        tx_word_t exp;
        logic     typ;
        get_transfer(word, typ);
        check_bit("tx_type", typ, 1'b0);
        exp.ch.pad = '0;
        exp.ch.chr = c;
        check_char("tx_data.ch", word, exp);
    endtask

    task automatic expect_value(input logic [`TRACE_WORD_W-1:0] v);
        tx_word_t word;
        tx_word_t exp;
        logic     typ;
        get_transfer(word, typ);
        check_bit("tx_type", typ, 1'b1);
        exp.data = v;
        check_value("tx_data.data", word, exp);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            if (tx_req === 1'b1) stop_with_error("Extra transmit request after the line end");
            cycles++;
            if (cycles > TIMEOUT) stop_with_error("Timeout: done never came after the line end");
        end while (done !== 1'b1);
    endtask

    task automatic run_dump(input int pat);
        int                        base;
        int                        f;
        int                        k;
        int                        pulse_base;
        int                        xfer_base;
        logic [`TRACE_WORD_W-1:0]  label;
        logic [`TRACE_CHAR_W-1:0]  c;
        base       = pat * `TRACE_FIELDS * 2;
        pulse_base = cpu_pulses;
        xfer_base  = transfers;
        apply_status(pat, '0);
        @(posedge clk);
        mode <= `TRACE_CMD;
        wait_request();
        check_count("clk_cpu pulses before tx_req", cpu_pulses - pulse_base, 1);
        apply_status(pat, '1);  // Snapshot must already be taken
        for (f = 0; f < `TRACE_FIELDS; f++) begin
            label = pat_mem[base + 2 * f];
            for (k = 0; k < `TRACE_LABEL_MAX; k++) begin
                c = label[(`TRACE_LABEL_MAX - 1 - k) * `TRACE_CHAR_W +: `TRACE_CHAR_W];
                if (c != '0) expect_char(c);
            end
            expect_value(pat_mem[base + 2 * f + 1]);
        end
        expect_char(`ASCII_CR);
        expect_char(`ASCII_LF);
        wait_done();
        @(posedge clk);
        mode <= 8'h00;
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_count("transfers", transfers - xfer_base, XFERS);
        check_count("clk_cpu pulses", cpu_pulses - pulse_base, 1);
    endtask

    // Leave the mode while a request is still unanswered
    task automatic abort_dump(input int pat);
        logic [`TRACE_WORD_W-1:0] label;
        int                       cycles;
        label = pat_mem[pat * `TRACE_FIELDS * 2];
        apply_status(pat, '0);
        @(posedge clk);
        mode <= `TRACE_CMD;
        expect_char(label[31:24]);
        expect_char(label[23:16]);
        wait_request();
        @(posedge clk);
        mode <= 8'h00;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 2) stop_with_error("tx_req still high two cycles after the abort");
        end while (tx_req !== 1'b0);
        quiet_cycles(20);
    endtask

    initial begin
        int p;
        seed   = 32'haddd;
        rstn   = 1'b0;
        mode   = 8'h00;
        tx_ack = 1'b0;
        npc    = '0;
        pc     = '0;
        ir     = '0;
        ctl    = '0;
        a      = '0;
        b      = '0;
        imm    = '0;
        y      = '0;
        mdr    = '0;
        $readmemh("verification/trace_patterns.txt", pat_mem);
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        quiet_cycles(8);
        @(posedge clk);
        mode <= 8'h55;  // Other command leaves the unit idle
        quiet_cycles(8);
        @(posedge clk);
        mode <= 8'h00;
        for (p = 0; p < PATTERNS; p++) begin
            run_dump(p);
            quiet_cycles(4);
        end
        abort_dump(1);
        run_dump(2);
        quiet_cycles(4);
        if (dut_i.assert_i.fail_count != 0) begin
            stop_with_error($sformatf("%0d assertion failures in the transmit handshake",
                                      dut_i.assert_i.fail_count));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/trace_patterns.txt
// Columns: expected label (ASCII, left aligned, zero padded), status value
// Four dumps of nine lines in the order NPC, PC, IR, CTL, A, B, IMM, Y, MDR
4E50433D 00000104
50433D00 00000100
49523D00 8C220008
43544C3D 0000A3C1
413D0000 00001000
423D0000 00000000
494D4D3D 00000008
593D0000 00001008
4D44523D DEADBEEF
4E50433D 00000108
50433D00 00000104
49523D00 00432820
43544C3D 00001A05
413D0000 00000003
423D0000 00000004
494D4D3D 00002820
593D0000 00000007
4D44523D 00000000
4E50433D 0000012C
50433D00 00000108
49523D00 1085FFF8
43544C3D 00008C22
413D0000 FFFFFFFF
423D0000 80000000
494D4D3D FFFFFFF8
593D0000 7FFFFFFF
4D44523D 12345678
4E50433D 00400000
50433D00 003FFFFC
49523D00 AC450010
43544C3D 0000F00F
413D0000 0F0F0F0F
423D0000 A5A5A5A5
494D4D3D 00000010
593D0000 0F0F0F1F
4D44523D 5A5A5A5A

//--- vlog.f
+incdir+source
source/trace_pkg.sv
source/trace_if.sv
source/trace_ctrl.sv
source/label_rom.sv
source/status_capture.sv
source/tx_port.sv
source/trace_top.sv
verification/trace_assert.sv
verification/trace_tb.sv

//--- Makefile
TOP = trace_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
